// ==== vlog.f ====
+incdir+include
rtl/icache_pkg.sv
rtl/icache_refill_if.sv
rtl/icache_ways.sv
rtl/icache_ctrl.sv
rtl/icache_axi_rd.sv
rtl/icache_top.sv
verif/icache_sva.sv
verif/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/icache_pkg.sv
      - rtl/icache_refill_if.sv
      - rtl/icache_ways.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_axi_rd.sv
      - rtl/icache_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/icache_sva.sv
      - verif/tb_icache.sv

// ==== verif/tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module tb_icache;

   localparam int          SEED        = 68864;
   localparam int          TEST_CYCLES = 1000;                 // Rough length of all sequences
   localparam int          WATCHDOG_NS = 2 * TEST_CYCLES * 10; // Margin of two

   logic                   clk = 1'b0;
   logic                   i_reset;
   logic                   i_fetch_en;
   logic [`IC_AW-1:0]      i_fetch_addr;
   logic                   i_inv_we;
   logic [`IC_AW-1:0]      i_inv_addr;
   logic                   i_ar_ready;
   logic                   i_r_valid;
   logic [`IC_BEAT_DW-1:0] i_r_data;
   logic                   i_r_last;
   logic                   o_stall;
   logic [`IC_BEAT_DW-1:0] o_insn;
   logic                   o_insn_valid;
   logic                   o_ar_valid;
   logic [`IC_AW-1:0]      o_ar_addr;
   logic                   o_r_ready;

   logic [`IC_AW-1:0]      exp_q [$];       // Accepted fetch addresses in fetch order
   int                     acc_cyc_q [$];
   int                     cyc = 0;
   int                     accepted_cnt = 0;
   int                     delivered_cnt = 0;
   int                     req_cnt = 0;
   int                     last_lat = 0;
   logic [`IC_AW-1:0]      last_ar_addr;
   logic                   bp_en;           // Random bus back-pressure
   logic [31:0]            rng = SEED;
   logic                   mem_busy;
   logic [1:0]             mem_beat;
   logic [`IC_AW-1:0]      mem_base;

   always #5 clk = ~clk;

   icache_top i_icache_top (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_fetch_en   (i_fetch_en),
      .i_fetch_addr (i_fetch_addr),
      .i_inv_we     (i_inv_we),
      .i_inv_addr   (i_inv_addr),
      .o_stall      (o_stall),
      .o_insn       (o_insn),
      .o_insn_valid (o_insn_valid),
      .i_ar_ready   (i_ar_ready),
      .o_ar_valid   (o_ar_valid),
      .o_ar_addr    (o_ar_addr),
      .i_r_valid    (i_r_valid),
      .i_r_data     (i_r_data),
      .i_r_last     (i_r_last),
      .o_r_ready    (o_r_ready)
   );

   bind icache_top icache_sva i_icache_sva (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ar_ready (i_ar_ready),
      .i_ar_valid (o_ar_valid),
      .i_ar_addr  (o_ar_addr),
      .i_r_ready  (o_r_ready),
      .i_stall    (o_stall)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   // Memory model returns ~A for the word at byte address A
   always @(posedge clk)
   begin
      if (i_reset)
      begin
         i_ar_ready <= 1'b0;
         i_r_valid  <= 1'b0;
         i_r_last   <= 1'b0;
         mem_busy   = 1'b0;
         mem_beat   = '0;
      end
      else
      begin
         rng = xorshift(rng);
         if (i_r_valid && o_r_ready)
         begin
            if (mem_beat == 2'd3)
               mem_busy = 1'b0;  // Burst done
            mem_beat = mem_beat + 1'b1;
         end
         if (o_ar_valid && i_ar_ready)
         begin
            mem_busy = 1'b1;
            mem_beat = '0;
            mem_base = o_ar_addr;
         end
         if (mem_busy && (!bp_en || rng[0] || rng[1]))
         begin
            i_r_valid <= 1'b1;
            i_r_data  <= ~(mem_base + {mem_beat, 2'b00});
            i_r_last  <= (mem_beat == 2'd3);
         end
         else
         begin
            i_r_valid <= 1'b0;  // Gap
            i_r_last  <= 1'b0;
         end
         i_ar_ready <= !bp_en || rng[4];
      end
   end

   // Fetch and bus monitor with data check
   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      assert (i_icache_top.i_icache_sva.fail_cnt == 0)
         else abort_run("A bus protocol assertion failed");
      if (!i_reset)
      begin
         if (o_insn_valid)
         begin
            assert (exp_q.size() > 0)
               else abort_run("Instruction delivered with no fetch outstanding");
            assert (o_insn == ~exp_q[0])
               else abort_run($sformatf("FAILED o_insn expected %08h got %08h",
                                        ~exp_q[0], o_insn));
            last_lat      <= cyc - acc_cyc_q[0];
            delivered_cnt <= delivered_cnt + 1;
            void'(exp_q.pop_front());
            void'(acc_cyc_q.pop_front());
         end
         if (i_fetch_en && !o_stall)
         begin
            exp_q.push_back(i_fetch_addr);
            acc_cyc_q.push_back(cyc);
            accepted_cnt <= accepted_cnt + 1;
         end
         if (o_ar_valid && i_ar_ready)
         begin
            req_cnt      <= req_cnt + 1;
            last_ar_addr <= o_ar_addr;
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      abort_run("Watchdog timeout, the test sequences did not finish");
   end

   // Single fetch with its delivery latency and new bus requests
   task automatic fetch_one(input logic [`IC_AW-1:0] addr, output int lat, output int reqs);
      int d0;
      int r0;
      d0 = delivered_cnt;
      r0 = req_cnt;
      i_fetch_en   <= 1'b1;
      i_fetch_addr <= addr;
      @(posedge clk);
      while (o_stall)
         @(posedge clk);
      i_fetch_en <= 1'b0;
      while (delivered_cnt == d0)
         @(posedge clk);
      lat  = last_lat;
      reqs = req_cnt - r0;
   endtask

   task automatic expect_hit(input logic [`IC_AW-1:0] addr);
      int lat;
      int reqs;
      fetch_one(addr, lat, reqs);
      assert (lat == 2)
         else abort_run($sformatf("FAILED o_insn_valid latency expected %h got %h", 2, lat));
      assert (reqs == 0)
         else abort_run($sformatf("FAILED o_ar_valid requests expected %h got %h",
                                  0, reqs));
   endtask

   task automatic expect_miss(input logic [`IC_AW-1:0] addr);
      int lat;
      int reqs;
      fetch_one(addr, lat, reqs);
      assert (reqs == 1)
         else abort_run($sformatf("FAILED o_ar_valid requests expected %h got %h",
                                  1, reqs));
      assert (last_ar_addr == {addr[`IC_AW-1:`IC_P_LINE], {`IC_P_LINE{1'b0}}})
         else abort_run($sformatf("FAILED o_ar_addr expected %08h got %08h",
                                  {addr[`IC_AW-1:`IC_P_LINE], {`IC_P_LINE{1'b0}}},
                                  last_ar_addr));
   endtask

   task automatic invalidate_line(input logic [`IC_AW-1:0] addr);
      i_inv_we   <= 1'b1;
      i_inv_addr <= addr;
      @(posedge clk);
      while (o_stall)
         @(posedge clk);
      i_inv_we <= 1'b0;
   endtask

   // Back-to-back fetches over a few conflicting lines
   task automatic fetch_stream(input int count);
      logic [`IC_AW-1:0] a;
      for (int i = 0; i < count; i++)
      begin
         a = 32'h0002_0000 + (i % 3) * 32'h400 + (i % 5) * 16 + (i % 4) * 4;
         i_fetch_en   <= 1'b1;
         i_fetch_addr <= a;
         @(posedge clk);
         while (o_stall)
            @(posedge clk);
      end
      i_fetch_en <= 1'b0;
      @(posedge clk);
      while (delivered_cnt != accepted_cnt)
         @(posedge clk);
   endtask

   initial
   begin
      int                  boot_cycles;
      logic [`IC_AW-1:0]   a;
      logic [`IC_AW-1:0]   b;
      i_reset      = 1'b1;
      i_fetch_en   = 1'b0;
      i_fetch_addr = '0;
      i_inv_we     = 1'b0;
      i_inv_addr   = '0;
      i_ar_ready   = 1'b0;
      i_r_valid    = 1'b0;
      i_r_data     = '0;
      i_r_last     = 1'b0;
      bp_en        = 1'b0;
      repeat (2) @(posedge clk);
      i_reset <= 1'b0;

      // Boot sweep clears one set per cycle
      boot_cycles = 0;
      @(posedge clk);
      while (o_stall)
      begin
         assert (!o_ar_valid) else abort_run("Address request issued during boot");
         boot_cycles++;
         @(posedge clk);
      end
      assert (boot_cycles == (1 << `IC_P_SETS))
         else abort_run($sformatf("FAILED o_stall boot cycles expected %h got %h",
                                  1 << `IC_P_SETS, boot_cycles));

      a = 32'h0001_0238;
      expect_miss(a);                 // Cold miss
      expect_hit(32'h0001_0230);
      expect_hit(32'h0001_0234);
      expect_hit(32'h0001_023c);
      expect_hit(a);

      invalidate_line(a);
      expect_miss(a);
      expect_hit(32'h0001_0234);

      // Three tags on one set
      b = 32'h0000_3054;
      expect_miss(b);
      expect_miss(b + 32'h400);
      expect_miss(b + 32'h800);       // Takes way 0 from b
      expect_hit(b + 32'h400);
      expect_miss(b);

      bp_en <= 1'b1;
      fetch_stream(32);
      repeat (4) @(posedge clk);

      if (i_icache_top.i_icache_sva.fail_cnt == 0)
      begin
         $display("Test OK");
         $finish;
      end
      else
         abort_run("A bus protocol assertion failed");
   end

endmodule

// ==== verif/icache_sva.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_sva
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_ar_ready,
   input  logic                        i_ar_valid,
   input  logic [`IC_AW-1:0]           i_ar_addr,
   input  logic                        i_r_ready,
   input  logic                        i_stall
);

   int unsigned                        fail_cnt = 0;  // Assertion failures so far

   // Address channel holds until accepted
   a_ar_hold : assert property (@(posedge clk) disable iff (i_reset)
      i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar_addr))
   else
   begin
      fail_cnt++;
      $error("AR valid or address changed while ready was low");
   end

   // Data phase opens only after the address went out
   a_no_early_rready : assert property (@(posedge clk) disable iff (i_reset)
      i_ar_valid |-> !i_r_ready)
   else
   begin
      fail_cnt++;
      $error("R ready high while a new line address is pending");
   end

   a_bus_stalled : assert property (@(posedge clk) disable iff (i_reset)
      (i_ar_valid || i_r_ready) |-> i_stall)  // Refills happen only with the pipeline frozen
   else
   begin
      fail_cnt++;
      $error("Bus activity while the fetch pipeline was not stalled");
   end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top
(
   input  logic                        clk,
   input  logic                        i_reset,
   // Fetch side
   input  logic                        i_fetch_en,
   input  logic [`IC_AW-1:0]           i_fetch_addr,
   input  logic                        i_inv_we,
   input  logic [`IC_AW-1:0]           i_inv_addr,
   output logic                        o_stall,
   output logic [`IC_BEAT_DW-1:0]      o_insn,
   output logic                        o_insn_valid,
   // AXI read channels
   input  logic                        i_ar_ready,
   output logic                        o_ar_valid,
   output logic [`IC_AW-1:0]           o_ar_addr,
   input  logic                        i_r_valid,
   input  logic [`IC_BEAT_DW-1:0]      i_r_data,
   input  logic                        i_r_last,
   output logic                        o_r_ready
);

   logic                               rd_en;
   icache_pkg::set_idx_t               rd_set;
   icache_pkg::beat_idx_t              rd_beat;
   icache_pkg::tag_t                   lookup_tag;
   icache_pkg::way_vec_t               tag_we;
   icache_pkg::set_idx_t               tag_set;
   icache_pkg::tag_t                   tag_wdata;
   logic                               tag_valid;
   icache_pkg::way_vec_t               data_we;
   icache_pkg::set_idx_t               data_set;
   icache_pkg::beat_idx_t              data_beat;
   logic [`IC_BEAT_DW-1:0]             data_wdata;
   logic                               hit;
   logic [`IC_BEAT_DW-1:0]             hit_word;

   icache_refill_if refill_if ();

   icache_ctrl i_icache_ctrl (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_fetch_en   (i_fetch_en),
      .i_fetch_addr (i_fetch_addr),
      .i_inv_we     (i_inv_we),
      .i_inv_addr   (i_inv_addr),
      .i_hit        (hit),
      .i_hit_word   (hit_word),
      .o_stall      (o_stall),
      .o_insn       (o_insn),
      .o_insn_valid (o_insn_valid),
      .o_rd_en      (rd_en),
      .o_rd_set     (rd_set),
      .o_rd_beat    (rd_beat),
      .o_tag_we     (tag_we),
      .o_tag_set    (tag_set),
      .o_tag_wdata  (tag_wdata),
      .o_tag_valid  (tag_valid),
      .o_data_we    (data_we),
      .o_data_set   (data_set),
      .o_data_beat  (data_beat),
      .o_data_wdata (data_wdata),
      .o_lookup_tag (lookup_tag),
      .refill       (refill_if.ctrl)
   );

   icache_ways i_icache_ways (
      .clk          (clk),
      .i_rd_en      (rd_en),
      .i_rd_set     (rd_set),
      .i_rd_beat    (rd_beat),
      .i_lookup_tag (lookup_tag),
      .i_tag_we     (tag_we),
      .i_tag_set    (tag_set),
      .i_tag_wdata  (tag_wdata),
      .i_tag_valid  (tag_valid),
      .i_data_we    (data_we),
      .i_data_set   (data_set),
      .i_data_beat  (data_beat),
      .i_data_wdata (data_wdata),
      .o_hit        (hit),
      .o_hit_word   (hit_word)
   );

   icache_axi_rd i_icache_axi_rd (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_ar_ready   (i_ar_ready),
      .i_r_valid    (i_r_valid),
      .i_r_data     (i_r_data),
      .i_r_last     (i_r_last),
      .o_ar_valid   (o_ar_valid),
      .o_ar_addr    (o_ar_addr),
      .o_r_ready    (o_r_ready),
      .refill       (refill_if.bus)
   );

endmodule

// ==== rtl/icache_axi_rd.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_axi_rd
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_ar_ready,
   input  logic                        i_r_valid,
   input  logic [`IC_BEAT_DW-1:0]      i_r_data,
   input  logic                        i_r_last,
   output logic                        o_ar_valid,
   output logic [`IC_AW-1:0]           o_ar_addr,
   output logic                        o_r_ready,
   icache_refill_if.bus                refill
);

   logic                               ar_hds;
   logic                               r_hds;
   logic                               refill_open;
   logic [`IC_AW-`IC_P_LINE-1:0]       line_q;
   icache_pkg::beat_idx_t              beat_cnt;

   assign ar_hds = o_ar_valid & i_ar_ready;
   assign r_hds  = i_r_valid & o_r_ready;

   // AR channel, set on request and cleared on handshake
   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         o_ar_valid <= 1'b0;
         line_q     <= '0;
      end
      else if (refill.req)
      begin
         o_ar_valid <= 1'b1;
         line_q     <= refill.line_addr;
      end
      else if (ar_hds)
         o_ar_valid <= 1'b0;
   end

   assign o_ar_addr = {line_q, {`IC_P_LINE{1'b0}}};  // Line aligned

   // Read data accepted only after the address went out
   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         refill_open <= 1'b0;
         beat_cnt    <= '0;
      end
      else
      begin
         if (ar_hds)
            refill_open <= 1'b1;
         else if (r_hds & i_r_last)
            refill_open <= 1'b0;
         if (ar_hds)
            beat_cnt <= '0;
         else if (r_hds)
            beat_cnt <= beat_cnt + 1'b1;
      end
   end

   assign o_r_ready = refill_open;

   assign refill.beat_valid = r_hds;
   assign refill.beat_idx   = beat_cnt;
   assign refill.beat_data  = i_r_data;
   assign refill.beat_last  = r_hds & i_r_last;

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ctrl
(
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_fetch_en,
   input  logic [`IC_AW-1:0]           i_fetch_addr,
   input  logic                        i_inv_we,
   input  logic [`IC_AW-1:0]           i_inv_addr,
   input  logic                        i_hit,
   input  logic [`IC_BEAT_DW-1:0]      i_hit_word,
   output logic                        o_stall,
   output logic [`IC_BEAT_DW-1:0]      o_insn,
   output logic                        o_insn_valid,
   output logic                        o_rd_en,
   output icache_pkg::set_idx_t        o_rd_set,
   output icache_pkg::beat_idx_t       o_rd_beat,
   output icache_pkg::way_vec_t        o_tag_we,
   output icache_pkg::set_idx_t        o_tag_set,
   output icache_pkg::tag_t            o_tag_wdata,
   output logic                        o_tag_valid,
   output icache_pkg::way_vec_t        o_data_we,
   output icache_pkg::set_idx_t        o_data_set,
   output icache_pkg::beat_idx_t       o_data_beat,
   output logic [`IC_BEAT_DW-1:0]      o_data_wdata,
   output icache_pkg::tag_t            o_lookup_tag,
   icache_refill_if.ctrl               refill
);

   localparam int BEAT_W   = $clog2(`IC_BEATS);
   localparam int WORD_LSB = `IC_P_LINE - BEAT_W;

   icache_pkg::ic_state_e              state_q;
   icache_pkg::ic_state_e              state_d;
   icache_pkg::set_idx_t               boot_cnt;
   icache_pkg::set_idx_t               inv_set;
   icache_pkg::way_vec_t               victim_ptr;
   icache_pkg::way_vec_t               refill_way;
   logic                               p_ce;
   logic                               miss;
   logic                               refill_get_word;
   logic                               s1_valid;
   logic [`IC_AW-1:0]                  s1_addr;
   logic                               s2_valid;     // Missed fetch parked in stage 2
   logic [`IC_AW-1:0]                  s2_addr;

   assign p_ce    = (state_q == icache_pkg::IDLE);  // Pipeline moves only in IDLE
   assign o_stall = ~p_ce;
   assign miss    = s1_valid & ~i_hit;

   // Beat carrying the word of the stalled fetch
   assign refill_get_word = refill.beat_valid &
                            (refill.beat_idx == s2_addr[WORD_LSB +: BEAT_W]);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         icache_pkg::BOOT:
            if (boot_cnt == '1)
               state_d = icache_pkg::IDLE;
         icache_pkg::IDLE:
            if (i_inv_we)
               state_d = icache_pkg::INVALIDATE;
            else if (miss)
               state_d = icache_pkg::REPLACE;
         icache_pkg::INVALIDATE:
            state_d = s2_valid ? icache_pkg::REPLACE : icache_pkg::RELOAD; // Resume a parked miss
         icache_pkg::REPLACE:
            state_d = icache_pkg::REFILL;
         icache_pkg::REFILL:
            if (refill.beat_last)
               state_d = icache_pkg::RELOAD;
         icache_pkg::RELOAD:
            state_d = icache_pkg::IDLE;
         default:
            state_d = icache_pkg::BOOT;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         state_q    <= icache_pkg::BOOT;
         boot_cnt   <= '0;
         victim_ptr <= icache_pkg::way_vec_t'(1);  // Way 0 first
         refill_way <= '0;
      end
      else
      begin
         state_q <= state_d;
         if (state_q == icache_pkg::BOOT)
            boot_cnt <= boot_cnt + 1'b1;
         if (state_q == icache_pkg::REPLACE)
         begin
            refill_way <= victim_ptr;
            victim_ptr <= {victim_ptr[0], victim_ptr[`IC_WAYS-1:1]};
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce & i_inv_we)
         inv_set <= i_inv_addr[`IC_P_LINE +: `IC_P_SETS];
   end

   // Stage registers
   always_ff @(posedge clk)
   begin
      if (i_reset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end
      else if (p_ce)
      begin
         s1_valid <= i_fetch_en;
         s2_valid <= miss;
      end
      else if (state_q == icache_pkg::RELOAD)
         s2_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         s1_addr <= i_fetch_addr;
         s2_addr <= s1_addr;
      end
   end

   // Output register, hit path or forwarded refill beat
   always_ff @(posedge clk)
   begin
      if (i_reset)
         o_insn_valid <= 1'b0;
      else
         o_insn_valid <= (p_ce & s1_valid & i_hit) |
                         ((state_q == icache_pkg::RELOAD) & s2_valid);
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
         o_insn <= i_hit_word;
      else if ((state_q == icache_pkg::REFILL) & refill_get_word)
         o_insn <= refill.beat_data;
   end

   // Array addressing by state
   always_comb
   begin
      o_rd_en   = p_ce | (state_q == icache_pkg::RELOAD);
      o_rd_set  = i_fetch_addr[`IC_P_LINE +: `IC_P_SETS];
      o_rd_beat = i_fetch_addr[WORD_LSB +: BEAT_W];
      if (state_q == icache_pkg::RELOAD)
      begin
         o_rd_set  = s1_addr[`IC_P_LINE +: `IC_P_SETS];  // Look up the held fetch again
         o_rd_beat = s1_addr[WORD_LSB +: BEAT_W];
      end

      o_tag_we    = '0;
      o_tag_set   = s2_addr[`IC_P_LINE +: `IC_P_SETS];
      o_tag_valid = 1'b0;
      case (state_q)
         icache_pkg::BOOT:
         begin
            o_tag_we  = '1;
            o_tag_set = boot_cnt;
         end
         icache_pkg::INVALIDATE:
         begin
            o_tag_we  = '1;
            o_tag_set = inv_set;
         end
         icache_pkg::REPLACE:
         begin
            o_tag_we    = victim_ptr;
            o_tag_valid = 1'b1;
         end
         default: ;
      endcase
   end

   assign o_tag_wdata  = s2_addr[`IC_AW-1 -: `IC_TAG_W];
   assign o_lookup_tag = s1_addr[`IC_AW-1 -: `IC_TAG_W];

   assign o_data_we    = ((state_q == icache_pkg::REFILL) & refill.beat_valid) ? refill_way : '0;
   assign o_data_set   = s2_addr[`IC_P_LINE +: `IC_P_SETS];
   assign o_data_beat  = refill.beat_idx;
   assign o_data_wdata = refill.beat_data;

   assign refill.req       = (state_q == icache_pkg::REPLACE);
   assign refill.line_addr = s2_addr[`IC_AW-1:`IC_P_LINE];

endmodule

// ==== rtl/icache_ways.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ways
(
   input  logic                        clk,
   // Lookup read port
   input  logic                        i_rd_en,
   input  icache_pkg::set_idx_t        i_rd_set,
   input  icache_pkg::beat_idx_t       i_rd_beat,
   input  icache_pkg::tag_t            i_lookup_tag,
   // Tag/valid write port
   input  icache_pkg::way_vec_t        i_tag_we,
   input  icache_pkg::set_idx_t        i_tag_set,
   input  icache_pkg::tag_t            i_tag_wdata,
   input  logic                        i_tag_valid,
   // Payload write port
   input  icache_pkg::way_vec_t        i_data_we,
   input  icache_pkg::set_idx_t        i_data_set,
   input  icache_pkg::beat_idx_t       i_data_beat,
   input  logic [`IC_BEAT_DW-1:0]      i_data_wdata,
   output logic                        o_hit,
   output logic [`IC_BEAT_DW-1:0]      o_hit_word
);

   localparam int SETS  = 1 << `IC_P_SETS;
   localparam int WORDS = SETS * `IC_BEATS;

   icache_pkg::way_vec_t               hit_vec;
   logic [`IC_BEAT_DW-1:0]             sel_word [`IC_WAYS];

   for (genvar w = 0; w < `IC_WAYS; w++)
   begin : g_way
      logic [`IC_TAG_W:0]              tag_v_mem [SETS];  // {tag, valid}
      logic [`IC_BEAT_DW-1:0]          data_mem  [WORDS];
      logic [`IC_TAG_W:0]              tag_v_q;
      logic [`IC_BEAT_DW-1:0]          word_q;

      always_ff @(posedge clk)
      begin
         if (i_tag_we[w])
            tag_v_mem[i_tag_set] <= {i_tag_wdata, i_tag_valid};
      end

      always_ff @(posedge clk)
      begin
         if (i_data_we[w])
            data_mem[{i_data_set, i_data_beat}] <= i_data_wdata;
      end

      // Registered reads, held while the pipeline is frozen
      always_ff @(posedge clk)
      begin
         if (i_rd_en)
         begin
            tag_v_q <= tag_v_mem[i_rd_set];
            word_q  <= data_mem[{i_rd_set, i_rd_beat}];
         end
      end

      assign hit_vec[w]  = tag_v_q[0] & (tag_v_q[`IC_TAG_W:1] == i_lookup_tag);
      assign sel_word[w] = word_q & {`IC_BEAT_DW{hit_vec[w]}};
   end

   assign o_hit = |hit_vec;

   // AND-OR select, at most one way matches
   always_comb
   begin
      o_hit_word = '0;
      for (int w = 0; w < `IC_WAYS; w++)
         o_hit_word = o_hit_word | sel_word[w];
   end

endmodule

// ==== rtl/icache_refill_if.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

interface icache_refill_if;

   logic                               req;         // One-cycle refill request
   logic [`IC_AW-`IC_P_LINE-1:0]       line_addr;   // Tag and set of the line
   logic                               beat_valid;  // Accepted read beat
   icache_pkg::beat_idx_t              beat_idx;    // Word position in line
   logic [`IC_BEAT_DW-1:0]             beat_data;
   logic                               beat_last;   // Final beat of the burst

   modport ctrl (
      output req,
      output line_addr,
      input  beat_valid,
      input  beat_idx,
      input  beat_data,
      input  beat_last
   );

   modport bus (
      input  req,
      input  line_addr,
      output beat_valid,
      output beat_idx,
      output beat_data,
      output beat_last
   );

endinterface

// ==== rtl/icache_pkg.sv ====
`include "icache_params.svh"

package icache_pkg;

   // Controller FSM
   typedef enum logic [2:0] {
      BOOT       = 3'd0,
      IDLE       = 3'd1,
      INVALIDATE = 3'd2,
      REPLACE    = 3'd3,
      REFILL     = 3'd4,
      RELOAD     = 3'd5
   } ic_state_e;

   // Address fields
   typedef logic [`IC_P_SETS-1:0]          set_idx_t;
   typedef logic [`IC_TAG_W-1:0]           tag_t;
   typedef logic [$clog2(`IC_BEATS)-1:0]   beat_idx_t;

   // One bit per way, one-hot
   typedef logic [`IC_WAYS-1:0]            way_vec_t;

endpackage

// ==== include/icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Physical address width
`define IC_AW          32

// log2 of line size in bytes
`define IC_P_LINE      4

// log2 of number of sets
`define IC_P_SETS      6

// Associativity
`define IC_WAYS        2

// Bus beat width, also the instruction width
`define IC_BEAT_DW     32

// Beats per line refill
`define IC_BEATS       4

// Tag is what is left above set index and line offset
`define IC_TAG_W       (`IC_AW - `IC_P_SETS - `IC_P_LINE)

`endif
